//--- filelist.f
common/gfx_bus_pkg.sv
common/gfx_draw_pkg.sv
verilog/sys_mem.sv
verilog/gpu_regs.sv
gpu/gpu_rect_walk.sv
gpu/gpu_pixel_write.sv
verilog/frame_buffer.sv
verilog/gfx_top.sv
bench/gfx_asserts.sv
bench/gfx_tb.sv

//--- Makefile
# Verilator build and run for the graphics subsystem testbench

VERILATOR ?= verilator
TOP       ?= gfx_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)

//--- bench/gfx_tb.sv
// Testbench for gfx_top: clock, reset, CPU bus tasks, LFSR, display reads, directed tests
`default_nettype none

module gfx_tb;

	localparam int          MEM_WORDS  = 6144;
	localparam int          FB_WIDTH   = 32;
	localparam int          FB_HEIGHT  = 16;
	localparam int          FB_PIX     = FB_WIDTH * FB_HEIGHT;
	localparam int          CLK_PERIOD = 4;
	localparam logic [31:0] REG_BASE   = 32'(MEM_WORDS * 4);
	localparam logic [31:0] MEM_BASE   = 32'h0000_0FA0;     // Word 1000
	localparam int          MEM_N      = 64;
	localparam logic [31:0] IMG_BASE   = 32'h0000_4000;
	localparam int          IMG_W      = 20;
	localparam int          IMG_H      = 12;
	localparam int          POLL_LIMIT = 2 * FB_PIX;
	// Worst case per part: bus accesses take up to 3 cycles, display checks 2 per pixel
	localparam int          WAIT_CYC   = 3 * POLL_LIMIT;
	localparam int          CHECK_CYC  = 2 * FB_PIX + 8;
	localparam int          TEST_CYC   = 9 * MEM_N + 3 * IMG_W * IMG_H / 2
		+ 5 * WAIT_CYC + 6 * CHECK_CYC + 400;

	logic                   hdmi_pixClk;
	logic                   rst_n;
	gfx_bus_pkg::cpu_req_t  cpu_req;
	gfx_bus_pkg::cpu_resp_t cpu_resp;
	logic                   vsync;
	logic [10:0]            disp_x;
	logic [9:0]             disp_y;
	gfx_draw_pkg::pixel_t   disp_pixel;

	logic [31:0]            lfsr;
	logic [31:0]            mem_model [MEM_N];
	gfx_draw_pkg::pixel_t   img [IMG_W * IMG_H];
	gfx_draw_pkg::pixel_t   front_model [FB_PIX];
	gfx_draw_pkg::pixel_t   back_model [FB_PIX];

	gfx_top #(.MEM_WORDS(MEM_WORDS), .FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) i_dut (
		.hdmi_pixClk, .rst_n, .cpu_req, .cpu_resp, .vsync, .disp_x, .disp_y, .disp_pixel
	);

	initial begin
		hdmi_pixClk = 1'b0;
		forever #(CLK_PERIOD / 2) hdmi_pixClk = !hdmi_pixClk;
	end

	initial begin
		#(TEST_CYC * CLK_PERIOD);
		$display("Timeout: the tests were still running after %0d cycles", TEST_CYC);
		$display("TESTBENCH FAILED");
		$fatal(1, "Watchdog expired");
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
	endfunction

	// One LFSR step per output bit
	task automatic rand_bits(input int nbits, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < nbits; i++) begin
			val  = {val[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "Check failed");
		end
	endtask

	function automatic logic [31:0] reg_addr(input gfx_bus_pkg::reg_off_e off);
		return REG_BASE + 32'(off);
	endfunction

	// Called one time unit after an edge, returns one time unit after the ready edge
	task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
			input logic [3:0] wstrb, output logic [31:0] rdata);
		cpu_req.valid = 1'b1;
		cpu_req.addr  = addr;
		cpu_req.wdata = wdata;
		cpu_req.wstrb = wstrb;
		do begin
			@(posedge hdmi_pixClk);
			#1;
		end while (!cpu_resp.ready);
		rdata         = cpu_resp.rdata;
		cpu_req.valid = 1'b0;
	endtask

	task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata,
			input logic [3:0] wstrb);
		logic [31:0] unused;
		bus_access(addr, wdata, wstrb, unused);
	endtask

	task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
		bus_access(addr, 32'd0, 4'b0000, rdata);
	endtask

	task automatic disp_read(input int x, input int y, output gfx_draw_pkg::pixel_t pix);
		disp_x = 11'(x);
		disp_y = 10'(y);
		@(posedge hdmi_pixClk);
		#1;
		pix = disp_pixel;
	endtask

	task automatic check_display(input string what);
		gfx_draw_pkg::pixel_t pix;
		for (int y = 0; y < FB_HEIGHT; y++) begin
			for (int x = 0; x < FB_WIDTH; x++) begin
				disp_read(x, y, pix);
				check_eq(32'(pix), 32'(front_model[y * FB_WIDTH + x]),
					$sformatf("%s pixel (%0d,%0d)", what, x, y));
			end
		end
	endtask

	task automatic wait_idle();
		logic [31:0] rdata;
		int          polls;
		polls = 0;
		do begin
			bus_read(reg_addr(gfx_bus_pkg::REG_BUSY), rdata);
			polls++;
			if (polls > POLL_LIMIT) begin
				$display("GPU busy did not clear after %0d polls", POLL_LIMIT);
				$display("TESTBENCH FAILED");
				$fatal(1, "GPU stuck busy");
			end
		end while (rdata[0]);
	endtask

	task automatic swap_models();
		gfx_draw_pkg::pixel_t tmp;
		for (int i = 0; i < FB_PIX; i++) begin
			tmp            = front_model[i];
			front_model[i] = back_model[i];
			back_model[i]  = tmp;
		end
	endtask

	// Unsynced swap takes effect on the clock after the request pulse
	task automatic swap_now();
		bus_write(reg_addr(gfx_bus_pkg::REG_VSYNCED), 32'd0, 4'hF);
		bus_write(reg_addr(gfx_bus_pkg::REG_SWAP), 32'd1, 4'hF);
		repeat (2) @(posedge hdmi_pixClk);
		#1;
		swap_models();
	endtask

	task automatic start_draw(input int ax, input int ay, input int w, input int h,
			input int x, input int y);
		bus_write(reg_addr(gfx_bus_pkg::REG_ADDRESS), IMG_BASE, 4'hF);
		bus_write(reg_addr(gfx_bus_pkg::REG_ADDR_X), 32'(ax), 4'hF);
		bus_write(reg_addr(gfx_bus_pkg::REG_ADDR_Y), 32'(ay), 4'hF);
		bus_write(reg_addr(gfx_bus_pkg::REG_IMAGE_WIDTH), 32'(IMG_W), 4'hF);
		bus_write(reg_addr(gfx_bus_pkg::REG_WIDTH), 32'(w), 4'hF);
		bus_write(reg_addr(gfx_bus_pkg::REG_HEIGHT), 32'(h), 4'hF);
		bus_write(reg_addr(gfx_bus_pkg::REG_X), 32'(x), 4'hF);
		bus_write(reg_addr(gfx_bus_pkg::REG_Y), 32'(y), 4'hF);
		bus_write(reg_addr(gfx_bus_pkg::REG_DRAW), 32'd1, 4'hF);
	endtask

	// Source pixel index is (addr_y + row) * image_width + addr_x + col
	task automatic model_draw(input int ax, input int ay, input int w, input int h,
			input int x, input int y);
		for (int r = 0; r < h; r++) begin
			for (int c = 0; c < w; c++) begin
				if (x + c < FB_WIDTH && y + r < FB_HEIGHT) begin
					back_model[(y + r) * FB_WIDTH + x + c] = img[(ay + r) * IMG_W + ax + c];
				end
			end
		end
	endtask

	task automatic mem_readback();
		logic [31:0] val;
		logic [31:0] strb;
		logic [31:0] rdata;
		for (int i = 0; i < MEM_N; i++) begin
			rand_bits(32, val);
			mem_model[i] = val;
			bus_write(MEM_BASE + 32'(4 * i), val, 4'hF);
		end
		for (int i = 0; i < MEM_N; i++) begin
			rand_bits(32, val);
			rand_bits(4, strb);
			for (int b = 0; b < 4; b++) begin
				if (strb[b]) mem_model[i][8*b +: 8] = val[8*b +: 8];
			end
			bus_write(MEM_BASE + 32'(4 * i), val, strb[3:0]);
		end
		for (int i = 0; i < MEM_N; i++) begin
			bus_read(MEM_BASE + 32'(4 * i), rdata);
			check_eq(rdata, mem_model[i], $sformatf("memory word %0d", i));
		end
	endtask

	task automatic clear_screen(input gfx_draw_pkg::pixel_t color);
		bus_write(reg_addr(gfx_bus_pkg::REG_CLEAR_COLOR), 32'(color), 4'hF);
		bus_write(reg_addr(gfx_bus_pkg::REG_CLEAR), 32'd1, 4'hF);
		wait_idle();
		for (int i = 0; i < FB_PIX; i++) begin
			back_model[i] = color;
		end
		swap_now();
		check_display("clear");
	endtask

	task automatic draw_image();
		logic [31:0] val;
		for (int i = 0; i < IMG_W * IMG_H; i++) begin
			rand_bits(16, val);
			img[i] = val[15:0];
		end
		// Lower address halfword holds the even pixel
		for (int k = 0; k < IMG_W * IMG_H / 2; k++) begin
			bus_write(IMG_BASE + 32'(4 * k), {img[2*k+1], img[2*k]}, 4'hF);
		end
		start_draw(3, 2, 10, 6, 5, 4);
		wait_idle();
		model_draw(3, 2, 10, 6, 5, 4);
		swap_now();
		check_display("draw");
	endtask

	task automatic draw_clipped();
		start_draw(1, 0, 10, 8, 26, 12);
		wait_idle();
		model_draw(1, 0, 10, 8, 26, 12);
		swap_now();
		check_display("clip");
	endtask

	task automatic swap_on_vsync();
		logic [31:0] rdata;
		bus_write(reg_addr(gfx_bus_pkg::REG_VSYNCED), 32'd1, 4'hF);
		bus_write(reg_addr(gfx_bus_pkg::REG_SWAP), 32'd1, 4'hF);
		repeat (2) @(posedge hdmi_pixClk);
		#1;
		bus_read(reg_addr(gfx_bus_pkg::REG_SWAP), rdata);
		check_eq(rdata, 32'd1, "swap pending before vsync");
		bus_write(reg_addr(gfx_bus_pkg::REG_SWAP), 32'd1, 4'hF);
		bus_read(reg_addr(gfx_bus_pkg::REG_VSYNC), rdata);
		check_eq(rdata, 32'd0, "vsync level low");
		check_display("before vsync");
		vsync = 1'b1;
		@(posedge hdmi_pixClk);
		#1;
		swap_models();
		bus_read(reg_addr(gfx_bus_pkg::REG_VSYNC), rdata);
		check_eq(rdata, 32'd1, "vsync level high");
		bus_read(reg_addr(gfx_bus_pkg::REG_SWAP), rdata);
		check_eq(rdata, 32'd0, "swap done after vsync");
		check_display("after vsync");
		vsync = 1'b0;
	endtask

	// Memory reads wait behind the GPU fetches
	task automatic reads_during_draw();
		logic [31:0] rdata;
		start_draw(3, 2, 10, 6, 5, 4);
		bus_read(reg_addr(gfx_bus_pkg::REG_BUSY), rdata);
		check_eq(rdata, 32'd1, "busy during draw");
		for (int i = 0; i < 16; i++) begin
			bus_read(MEM_BASE + 32'(4 * i), rdata);
			check_eq(rdata, mem_model[i], $sformatf("memory word %0d during draw", i));
		end
		wait_idle();
	endtask

	initial begin
		lfsr    = 32'h32f6_0d40;
		rst_n   = 1'b0;
		cpu_req = '0;
		vsync   = 1'b0;
		disp_x  = '0;
		disp_y  = '0;
		repeat (8) @(posedge hdmi_pixClk);
		#1;
		rst_n = 1'b1;
		@(posedge hdmi_pixClk);
		#1;
		mem_readback();
		clear_screen(16'h1234);
		clear_screen(16'hF81F);
		draw_image();
		draw_clipped();
		swap_on_vsync();
		reads_during_draw();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/gfx_asserts.sv
// Concurrent assertions on the memory port and the GPU pipeline, with the bind into gfx_top
`default_nettype none

module gfx_asserts (
	input logic                  hdmi_pixClk,
	input logic                  rst_n,
	input logic                  mem_ready,
	input logic                  rd_en,
	input logic                  fb_we,
	input logic                  busy,
	input gfx_draw_pkg::gpu_op_e walk_op
);

	a_ready_pulse: assert property (
		@(posedge hdmi_pixClk) disable iff (!rst_n) mem_ready |=> !mem_ready
	) else $error("memory ready was high for two cycles in a row");

	// Draw writes land two cycles after their source read
	a_write_after_read: assert property (
		@(posedge hdmi_pixClk) disable iff (!rst_n)
		fb_we && walk_op == gfx_draw_pkg::GPU_OP_DRAW |-> $past(rd_en, 2)
	) else $error("framebuffer write without a source read two cycles earlier");

	a_idle_after_reset: assert property (
		@(posedge hdmi_pixClk) $rose(rst_n) |-> !busy
	) else $error("GPU busy right after reset");

endmodule

bind gfx_top gfx_asserts i_gfx_asserts (
	.hdmi_pixClk, .rst_n, .mem_ready(mem_resp.ready), .rd_en, .fb_we, .busy,
	.walk_op(walk_item.op)
);

`default_nettype wire

//--- verilog/gfx_top.sv
// Graphics top: memory, GPU registers, GPU pipeline stages, fetch register, framebuffer
`default_nettype none

module gfx_top #(
	parameter int MEM_WORDS = 6144,
	parameter int FB_WIDTH  = 32,
	parameter int FB_HEIGHT = 16
) (
	input  logic                   hdmi_pixClk,
	input  logic                   rst_n,
	input  gfx_bus_pkg::cpu_req_t  cpu_req,
	output gfx_bus_pkg::cpu_resp_t cpu_resp,
	input  logic                   vsync,
	input  logic [10:0]            disp_x,
	input  logic [9:0]             disp_y,
	output gfx_draw_pkg::pixel_t   disp_pixel
);

	gfx_bus_pkg::cpu_req_t   mem_req;
	gfx_bus_pkg::cpu_resp_t  mem_resp;
	gfx_draw_pkg::draw_cmd_t draw_cmd;
	gfx_draw_pkg::pix_item_t walk_item;
	gfx_draw_pkg::pix_item_t fetch_item;
	gfx_draw_pkg::pixel_t    rd_pixel;
	gfx_draw_pkg::pixel_t    fb_pixel;
	logic                    draw_start;
	logic                    clear_start;
	logic                    swap_req;
	logic                    vsynced;
	logic                    swap_pending;
	logic                    busy;
	logic                    rd_en;
	logic [31:0]             rd_addr;
	logic                    fb_we;
	logic [10:0]             fb_x;
	logic [9:0]              fb_y;

	sys_mem #(.MEM_WORDS(MEM_WORDS)) i_sys_mem (
		.hdmi_pixClk, .rst_n, .mem_req, .mem_resp, .rd_en, .rd_addr, .rd_pixel
	);

	gpu_regs #(.MEM_WORDS(MEM_WORDS)) i_gpu_regs (
		.hdmi_pixClk, .rst_n, .cpu_req, .cpu_resp, .mem_req, .mem_resp, .draw_cmd,
		.draw_start, .clear_start, .swap_req, .vsynced, .swap_pending, .busy, .vsync
	);

	gpu_rect_walk #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) i_gpu_rect_walk (
		.hdmi_pixClk, .rst_n, .draw_cmd, .draw_start, .clear_start,
		.item(walk_item), .rd_en, .rd_addr, .busy
	);

	// Fetch stage, item lines up with rd_pixel
	always_ff @(posedge hdmi_pixClk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_item <= '0;
		end else begin
			fetch_item <= walk_item;
		end
	end

	gpu_pixel_write #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) i_gpu_pixel_write (
		.hdmi_pixClk, .rst_n, .item(fetch_item), .rd_pixel, .fb_we, .fb_x, .fb_y, .fb_pixel
	);

	frame_buffer #(.FB_WIDTH(FB_WIDTH), .FB_HEIGHT(FB_HEIGHT)) i_frame_buffer (
		.hdmi_pixClk, .rst_n, .fb_we, .fb_x, .fb_y, .fb_pixel, .swap_req, .vsynced,
		.vsync, .swap_pending, .disp_x, .disp_y, .disp_pixel
	);

endmodule

`default_nettype wire

//--- verilog/frame_buffer.sv
// Double framebuffer: back-buffer write port, front-buffer display read, vsync swap
`default_nettype none

module frame_buffer #(
	parameter int FB_WIDTH  = 32,
	parameter int FB_HEIGHT = 16
) (
	input  logic                 hdmi_pixClk,
	input  logic                 rst_n,
	input  logic                 fb_we,
	input  logic [10:0]          fb_x,
	input  logic [9:0]           fb_y,
	input  gfx_draw_pkg::pixel_t fb_pixel,
	input  logic                 swap_req,
	input  logic                 vsynced,
	input  logic                 vsync,
	output logic                 swap_pending,
	input  logic [10:0]          disp_x,
	input  logic [9:0]           disp_y,
	output gfx_draw_pkg::pixel_t disp_pixel
);

	localparam int FB_PIX = FB_WIDTH * FB_HEIGHT;
	localparam int FB_AW  = $clog2(FB_PIX);

	gfx_draw_pkg::pixel_t fb_mem [2][FB_PIX];
	logic [FB_AW-1:0]     wr_idx;
	logic [FB_AW-1:0]     rd_idx;
	logic                 front_sel;
	logic                 vsync_q;
	logic                 vsync_rise;

	assign wr_idx     = FB_AW'(32'(fb_y) * FB_WIDTH + 32'(fb_x));
	assign rd_idx     = FB_AW'(32'(disp_y) * FB_WIDTH + 32'(disp_x));
	assign vsync_rise = vsync && !vsync_q;

	always_ff @(posedge hdmi_pixClk) begin
		if (fb_we) fb_mem[!front_sel][wr_idx] <= fb_pixel;     // Back buffer
		disp_pixel <= fb_mem[front_sel][rd_idx];
	end

	always_ff @(posedge hdmi_pixClk or negedge rst_n) begin
		if (!rst_n) begin
			front_sel    <= 1'b0;
			swap_pending <= 1'b0;
			vsync_q      <= 1'b0;
		end else begin
			vsync_q <= vsync;
			if (swap_req && !vsynced) begin
				front_sel <= !front_sel;
			end else if (swap_req) begin
				swap_pending <= 1'b1;   // Wait for the next rising edge
			end else if (swap_pending && vsync_rise) begin
				front_sel    <= !front_sel;
				swap_pending <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- gpu/gpu_pixel_write.sv
// GPU write stage: pixel source select, clipping, registered framebuffer write
`default_nettype none

module gpu_pixel_write #(
	parameter int FB_WIDTH  = 32,
	parameter int FB_HEIGHT = 16
) (
	input  logic                    hdmi_pixClk,
	input  logic                    rst_n,
	input  gfx_draw_pkg::pix_item_t item,
	input  gfx_draw_pkg::pixel_t    rd_pixel,
	output logic                    fb_we,
	output logic [10:0]             fb_x,
	output logic [9:0]              fb_y,
	output gfx_draw_pkg::pixel_t    fb_pixel
);

	logic                 in_range;
	gfx_draw_pkg::pixel_t pix_sel;

	assign in_range = 32'(item.dest_x) < FB_WIDTH && 32'(item.dest_y) < FB_HEIGHT;

	// rd_pixel already carries the halfword picked by the fetch address
	assign pix_sel = (item.op == gfx_draw_pkg::GPU_OP_CLEAR) ? item.color : rd_pixel;

	always_ff @(posedge hdmi_pixClk or negedge rst_n) begin
		if (!rst_n) begin
			fb_we <= 1'b0;
		end else begin
			fb_we <= item.valid && in_range;
		end
	end

	always_ff @(posedge hdmi_pixClk) begin
		fb_x     <= item.dest_x;
		fb_y     <= item.dest_y;
		fb_pixel <= pix_sel;
	end

endmodule

`default_nettype wire

//--- gpu/gpu_rect_walk.sv
// GPU walk stage: rectangle FSM, source read issue, destination items, busy
`default_nettype none

module gpu_rect_walk #(
	parameter int FB_WIDTH  = 32,
	parameter int FB_HEIGHT = 16
) (
	input  logic                    hdmi_pixClk,
	input  logic                    rst_n,
	input  gfx_draw_pkg::draw_cmd_t draw_cmd,
	input  logic                    draw_start,
	input  logic                    clear_start,
	output gfx_draw_pkg::pix_item_t item,
	output logic                    rd_en,
	output logic [31:0]             rd_addr,
	output logic                    busy
);

	typedef enum logic [1:0] {
		IDLE,
		WALK,
		DRAIN
	} state_e;

	state_e                  state;
	gfx_draw_pkg::gpu_op_e   op_q;
	gfx_draw_pkg::draw_cmd_t cmd_q;
	logic [10:0]             ext_w;
	logic [9:0]              ext_h;
	logic [10:0]             col;
	logic [9:0]              row;
	logic                    drain_cnt;
	logic [11:0]             sum_x;
	logic [10:0]             sum_y;
	logic [31:0]             src_off;

	always_ff @(posedge hdmi_pixClk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= IDLE;
			op_q      <= gfx_draw_pkg::GPU_OP_DRAW;
			ext_w     <= '0;
			ext_h     <= '0;
			col       <= '0;
			row       <= '0;
			drain_cnt <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					col <= '0;
					row <= '0;
					drain_cnt <= 1'b1;  // Fetch and write stages still to empty
					if (draw_start) begin
						op_q  <= gfx_draw_pkg::GPU_OP_DRAW;
						ext_w <= draw_cmd.width;
						ext_h <= draw_cmd.height;
						state <= (draw_cmd.width == '0 || draw_cmd.height == '0) ? DRAIN : WALK;
					end else if (clear_start) begin
						op_q  <= gfx_draw_pkg::GPU_OP_CLEAR;
						ext_w <= 11'(FB_WIDTH);
						ext_h <= 10'(FB_HEIGHT);
						state <= WALK;
					end
				end
				WALK: begin
					if (col == ext_w - 11'd1) begin
						col <= '0;
						if (row == ext_h - 10'd1) begin
							state <= DRAIN;
						end else begin
							row <= row + 10'd1;
						end
					end else begin
						col <= col + 11'd1;
					end
				end
				DRAIN: begin
					drain_cnt <= 1'b0;
					if (!drain_cnt) state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Command held for the whole walk
	always_ff @(posedge hdmi_pixClk) begin
		if (state == IDLE && (draw_start || clear_start)) cmd_q <= draw_cmd;
	end

	assign sum_x   = 12'(cmd_q.x) + 12'(col);
	assign sum_y   = 11'(cmd_q.y) + 11'(row);
	assign src_off = 32'(cmd_q.addr_x) + 32'(col)
		+ 32'(cmd_q.image_width) * (32'(cmd_q.addr_y) + 32'(row));
	assign rd_addr = cmd_q.src_addr + (src_off << 1);
	assign rd_en   = state == WALK && op_q == gfx_draw_pkg::GPU_OP_DRAW;
	assign busy    = state != IDLE;

	always_comb begin
		item.valid    = state == WALK;
		item.op       = op_q;
		item.half_sel = rd_addr[1];
		item.color    = cmd_q.clear_color;
		if (op_q == gfx_draw_pkg::GPU_OP_CLEAR) begin
			item.dest_x = col;
			item.dest_y = row;
		end else begin
			item.dest_x = sum_x[11] ? '1 : sum_x[10:0];     // Saturate so it clips
			item.dest_y = sum_y[10] ? '1 : sum_y[9:0];
		end
	end

endmodule

`default_nettype wire

//--- verilog/gpu_regs.sv
// GPU control registers: bus split, register decode, command pulses, status readback
`default_nettype none

module gpu_regs #(
	parameter int MEM_WORDS = 6144
) (
	input  logic                    hdmi_pixClk,
	input  logic                    rst_n,
	input  gfx_bus_pkg::cpu_req_t   cpu_req,
	output gfx_bus_pkg::cpu_resp_t  cpu_resp,
	output gfx_bus_pkg::cpu_req_t   mem_req,
	input  gfx_bus_pkg::cpu_resp_t  mem_resp,
	output gfx_draw_pkg::draw_cmd_t draw_cmd,
	output logic                    draw_start,
	output logic                    clear_start,
	output logic                    swap_req,
	output logic                    vsynced,
	input  logic                    swap_pending,
	input  logic                    busy,
	input  logic                    vsync
);

	localparam logic [31:0] REG_BASE = 32'(MEM_WORDS * 4);

	gfx_draw_pkg::draw_cmd_t cmd_q;
	logic [31:0]             off;
	logic                    is_mem;
	logic                    reg_hit;
	logic                    reg_go;
	logic                    reg_ready;
	logic [31:0]             reg_rdata;
	logic                    wr_ok;
	logic                    rd_ok;
	logic                    cmd_idle;

	assign is_mem   = cpu_req.addr < REG_BASE;
	assign off      = cpu_req.addr - REG_BASE;
	assign reg_hit  = off[31:12] == 20'd0;
	assign reg_go   = cpu_req.valid && !is_mem && !reg_ready;
	assign wr_ok    = &cpu_req.wstrb;
	assign rd_ok    = cpu_req.wstrb == 4'b0000;
	assign cmd_idle = !busy && !draw_start && !clear_start;

	always_comb begin
		mem_req       = cpu_req;
		mem_req.valid = cpu_req.valid && is_mem;
	end

	always_ff @(posedge hdmi_pixClk or negedge rst_n) begin
		if (!rst_n) begin
			reg_ready         <= 1'b0;
			reg_rdata         <= '0;
			cmd_q             <= '0;
			cmd_q.clear_color <= 16'hD8B7;
			draw_start        <= 1'b0;
			clear_start       <= 1'b0;
			swap_req          <= 1'b0;
			vsynced           <= 1'b1;
		end else begin
			reg_ready   <= reg_go;
			draw_start  <= 1'b0;
			clear_start <= 1'b0;
			swap_req    <= 1'b0;
			if (reg_go) begin
				reg_rdata <= '0;    // Unmapped and odd accesses read zero
				if (reg_hit) begin
					case (gfx_bus_pkg::reg_off_e'(off[11:0]))
						gfx_bus_pkg::REG_ADDRESS:     if (wr_ok) cmd_q.src_addr <= cpu_req.wdata;
						gfx_bus_pkg::REG_ADDR_X:      if (wr_ok) cmd_q.addr_x <= cpu_req.wdata[15:0];
						gfx_bus_pkg::REG_ADDR_Y:      if (wr_ok) cmd_q.addr_y <= cpu_req.wdata[15:0];
						gfx_bus_pkg::REG_IMAGE_WIDTH: begin
							if (wr_ok) cmd_q.image_width <= cpu_req.wdata[15:0];
						end
						gfx_bus_pkg::REG_WIDTH:       if (wr_ok) cmd_q.width <= cpu_req.wdata[10:0];
						gfx_bus_pkg::REG_HEIGHT:      if (wr_ok) cmd_q.height <= cpu_req.wdata[9:0];
						gfx_bus_pkg::REG_X:           if (wr_ok) cmd_q.x <= cpu_req.wdata[10:0];
						gfx_bus_pkg::REG_Y:           if (wr_ok) cmd_q.y <= cpu_req.wdata[9:0];
						gfx_bus_pkg::REG_DRAW:        if (wr_ok && cmd_idle) draw_start <= cpu_req.wdata[0];
						gfx_bus_pkg::REG_CLEAR_COLOR: begin
							if (wr_ok) cmd_q.clear_color <= cpu_req.wdata[15:0];
						end
						gfx_bus_pkg::REG_CLEAR:       if (wr_ok && cmd_idle) clear_start <= cpu_req.wdata[0];
						gfx_bus_pkg::REG_BUSY:        if (rd_ok) reg_rdata <= {31'd0, busy};
						gfx_bus_pkg::REG_SWAP: begin
							if (wr_ok && !swap_pending && !swap_req) begin
								swap_req <= cpu_req.wdata[0];   // Toggle guard
							end else if (rd_ok) begin
								reg_rdata <= {31'd0, swap_pending};
							end
						end
						gfx_bus_pkg::REG_VSYNC:       if (rd_ok) reg_rdata <= {31'd0, vsync};
						gfx_bus_pkg::REG_VSYNCED:     if (wr_ok) vsynced <= cpu_req.wdata[0];
						default: ;
					endcase
				end
			end
		end
	end

	assign draw_cmd = cmd_q;

	always_comb begin
		cpu_resp.ready = mem_resp.ready | reg_ready;
		cpu_resp.rdata = mem_resp.ready ? mem_resp.rdata : reg_rdata;
	end

endmodule

`default_nettype wire

//--- verilog/sys_mem.sv
// System memory: byte-strobed word array, GPU read port with priority, waiting CPU port
`default_nettype none

module sys_mem #(
	parameter int MEM_WORDS = 6144
) (
	input  logic                   hdmi_pixClk,
	input  logic                   rst_n,
	input  gfx_bus_pkg::cpu_req_t  mem_req,
	output gfx_bus_pkg::cpu_resp_t mem_resp,
	input  logic                   rd_en,
	input  logic [31:0]            rd_addr,
	output gfx_draw_pkg::pixel_t   rd_pixel
);

	localparam int AW = $clog2(MEM_WORDS);

	logic [31:0]   mem [MEM_WORDS];
	logic [AW-1:0] cpu_idx;
	logic [AW-1:0] rd_idx;
	logic          cpu_go;
	logic          ready_q;
	logic [31:0]   cpu_rdata;
	logic [31:0]   rd_word;
	logic          rd_half;

	assign cpu_idx = mem_req.addr[AW+1:2];
	assign rd_idx  = rd_addr[AW+1:2];

	// GPU owns the array in any cycle it reads
	assign cpu_go = mem_req.valid && !rd_en && !ready_q;

	always_ff @(posedge hdmi_pixClk) begin
		if (rd_en) begin
			rd_word <= mem[rd_idx];
			rd_half <= rd_addr[1];
		end
		if (cpu_go) begin
			for (int i = 0; i < 4; i++) begin
				if (mem_req.wstrb[i]) begin
					mem[cpu_idx][8*i +: 8] <= mem_req.wdata[8*i +: 8];
				end
			end
			if (mem_req.wstrb == 4'b0000) begin
				cpu_rdata <= mem[cpu_idx];
			end
		end
	end

	always_ff @(posedge hdmi_pixClk or negedge rst_n) begin
		if (!rst_n) begin
			ready_q <= 1'b0;
		end else begin
			ready_q <= cpu_go;      // Blocks a second access on the ready cycle
		end
	end

	always_comb begin
		mem_resp.ready = ready_q;
		mem_resp.rdata = cpu_rdata;
	end

	assign rd_pixel = rd_half ? rd_word[31:16] : rd_word[15:0];

endmodule

`default_nettype wire

//--- common/gfx_draw_pkg.sv
// Pixel type, GPU opcode enum, draw command struct and pipeline item struct
`default_nettype none

package gfx_draw_pkg;

	typedef logic [15:0] pixel_t;   // RGB565

	typedef enum logic {
		GPU_OP_DRAW,
		GPU_OP_CLEAR
	} gpu_op_e;

	// Command as it stands in the control registers
	typedef struct packed {
		logic [31:0] src_addr;      // Byte address of the source image
		logic [15:0] addr_x;
		logic [15:0] addr_y;
		logic [15:0] image_width;   // Source stride in pixels
		logic [10:0] width;
		logic [9:0]  height;
		logic [10:0] x;
		logic [9:0]  y;
		pixel_t      clear_color;
	} draw_cmd_t;

	// One pixel moving through walk, fetch and write
	typedef struct packed {
		logic        valid;
		gpu_op_e     op;
		logic [10:0] dest_x;
		logic [9:0]  dest_y;
		logic        half_sel;      // Source halfword, upper when set
		pixel_t      color;         // Clear colour
	} pix_item_t;

endpackage

`default_nettype wire

//--- common/gfx_bus_pkg.sv
// CPU bus request and response structs, GPU register offset enum
`default_nettype none

package gfx_bus_pkg;

	// One request as the CPU drives it; held until ready
	typedef struct packed {
		logic        valid;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  wstrb;     // All clear means read
	} cpu_req_t;

	typedef struct packed {
		logic        ready;     // One-cycle pulse
		logic [31:0] rdata;     // Valid with ready
	} cpu_resp_t;

	// Byte offsets from the register base, which sits just past memory
	typedef enum logic [11:0] {
		REG_ADDRESS     = 12'h000,
		REG_ADDR_X      = 12'h004,
		REG_ADDR_Y      = 12'h008,
		REG_IMAGE_WIDTH = 12'h00C,
		REG_WIDTH       = 12'h010,
		REG_HEIGHT      = 12'h014,
		REG_X           = 12'h018,
		REG_Y           = 12'h01C,
		REG_DRAW        = 12'h020,
		REG_CLEAR_COLOR = 12'h024,
		REG_CLEAR       = 12'h028,
		REG_BUSY        = 12'h02C,
		REG_SWAP        = 12'h100,
		REG_VSYNC       = 12'h108,
		REG_VSYNCED     = 12'h10C
	} reg_off_e;

endpackage

`default_nettype wire
